/* sources.f */
+incdir+source
source/hdmi_pkg.sv
source/video_timing.sv
source/ramp_pattern.sv
source/tmds_encoder.sv
source/tmds_serializer.sv
source/hdmi_tx_top.sv
test/hdmi_tx_assertions.sv
test/hdmi_tx_checker.sv
test/hdmi_tx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the HDMI transmitter testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module hdmi_tx_tb -Mdir "$OBJ_DIR" -f sources.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

"./$OBJ_DIR/Vhdmi_tx_tb" +verilator+error+limit+100 > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "tests failed" "$SIM_LOG"; then
  exit 1
fi

exit 0

/* test/hdmi_tx_tb.sv */
`timescale 1ns/100ps
`include "hdmi_cfg.svh"

module hdmi_tx_tb;

  localparam int CLK_PERIOD = 20;
  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL * `SYM_W;
  localparam int RUN_FRAMES = 6;
  localparam int LIMIT_FRAMES = 10;

  logic       clk50m_bufg;
  logic       serdes_rst;
  logic [3:0] tmds;
  int         pulse_start [3];
  int         pulse_count;
  int         tb_errors;

  hdmi_tx_top hdmi_tx_top_i (
    .clk50m_bufg (clk50m_bufg),
    .serdes_rst  (serdes_rst),
    .tmds        (tmds)
  );

  hdmi_tx_checker hdmi_tx_checker_i (
    .clk50m_bufg (clk50m_bufg),
    .serdes_rst  (serdes_rst),
    .tmds        (tmds)
  );

  // serializer timing checks
  bind tmds_serializer hdmi_tx_assertions serializer_assertions_i (
    .clk50m_bufg (clk50m_bufg),
    .serdes_rst  (serdes_rst),
    .pixel_tick  (pixel_tick),
    .tmds        (tmds)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    clk50m_bufg = 1'b0;
    forever #(CLK_PERIOD / 2) clk50m_bufg = ~clk50m_bufg;
  end

  ////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////

  initial begin
    logic [31:0] seed;
    int          slot;
    bit          in_pulse;
    int          total;
    serdes_rst = 1'b1;
    tb_errors = 0;
    seed = 32'h7296_3246;
    // one to three pulses, one per slot of frames 2..5
    seed = lcg_next(seed);
    pulse_count = 1 + int'(seed[31:16] % 16'd3);
    slot = 4 * FRAME_CYCLES / pulse_count;
    for (int i = 0; i < pulse_count; i++) begin
      seed = lcg_next(seed);
      pulse_start[i] = 2 * FRAME_CYCLES + i * slot + (int'(seed[31:8]) % (slot - 10));
    end
    repeat (2) @(negedge clk50m_bufg);
    serdes_rst = 1'b0;
    for (int cycle = 2; cycle < RUN_FRAMES * FRAME_CYCLES; cycle++) begin
      @(negedge clk50m_bufg);
      in_pulse = 1'b0;
      for (int i = 0; i < pulse_count; i++) begin
        if (cycle >= pulse_start[i] && cycle < pulse_start[i] + 2) begin
          in_pulse = 1'b1;
        end
      end
      serdes_rst = in_pulse;
    end
    // each reset costs at most one frame
    if (hdmi_tx_checker_i.frames_done < 2) begin
      $display("too few complete frames were checked: %0d", hdmi_tx_checker_i.frames_done);
      tb_errors++;
    end
    total = hdmi_tx_checker_i.errors + tb_errors +
            hdmi_tx_top_i.tmds_serializer_i.serializer_assertions_i.fail_count;
    $display("errors: checker %0d, assertions %0d, testbench %0d (%0d reset pulses)",
             hdmi_tx_checker_i.errors,
             hdmi_tx_top_i.tmds_serializer_i.serializer_assertions_i.fail_count,
             tb_errors, pulse_count);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog, well past the normal run length
  initial begin
    #(LIMIT_FRAMES * FRAME_CYCLES * CLK_PERIOD);
    $display("run did not finish within %0d frames", LIMIT_FRAMES);
    $display("tests failed");
    $finish;
  end

endmodule

/* test/hdmi_tx_checker.sv */
`timescale 1ns/100ps
`include "hdmi_cfg.svh"

module hdmi_tx_checker (
  input logic       clk50m_bufg,
  input logic       serdes_rst,
  input logic [3:0] tmds
);

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam logic SYNC_POL = 1'(`SYNC_NEG);
  localparam logic [9:0] CLK_WORD = 10'b0000011111;

  int errors = 0;
  int frames_done = 0;

  logic       prev3 = 1'b0;
  logic [9:0] word [4];
  bit         aligned = 1'b0;
  bit         post_rst = 1'b0;
  bit         synced = 1'b0;
  int         pos = 0;
  int         col = 0;
  int         line = 0;
  int         data_in_line = 0;
  int         active_lines = 0;
  int         disp [3];

  //////////////////////////////////////////////////
  // reporting and symbol decode
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input int unsigned exp_val,
                                 input int unsigned act_val);
    $display("CHECK FAILED t=%0t %s: expected %0h actual %0h", $time, name, exp_val, act_val);
    errors++;
  endtask

  // control words, 3rd bit flags a match
  function automatic logic [2:0] ctl_lookup(input logic [9:0] s);
    case (s)
      10'b1101010100: return 3'b100;
      10'b0010101011: return 3'b101;
      10'b0101010100: return 3'b110;
      10'b1010101011: return 3'b111;
      default:        return 3'b000;
    endcase
  endfunction

  // undo inversion, then the xor or xnor chain
  function automatic logic [7:0] decode_data(input logic [9:0] s);
    logic [7:0] d;
    logic [7:0] q;
    d = s[9] ? ~s[7:0] : s[7:0];
    q[0] = d[0];
    for (int i = 1; i < 8; i++) begin
      q[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return q;
  endfunction

  function automatic int ones_minus_zeros(input logic [9:0] s);
    return 2 * $countones(s) - 10;
  endfunction

  //////////////////////////////////////////////////
  // frame model
  //////////////////////////////////////////////////

  task automatic check_word();
    logic [2:0] lk [3];
    logic       active;
    logic       hs;
    logic       vs;
    logic [1:0] exp_pair;
    int         exp_data;
    if (word[3] != CLK_WORD) begin
      report_mismatch("lane3 clock word", 32'(CLK_WORD), 32'(word[3]));
    end
    for (int l = 0; l < 3; l++) begin
      lk[l] = ctl_lookup(word[l]);
    end
    // before resync only idle blanking is allowed
    if (!synced) begin
      if (!lk[0][2]) begin
        synced = 1'b1;
        col = 0;
        line = 0;
        data_in_line = 0;
        active_lines = 0;
        for (int l = 0; l < 3; l++) begin
          disp[l] = 0;
        end
      end else begin
        for (int l = 0; l < 3; l++) begin
          if (!lk[l][2]) begin
            report_mismatch($sformatf("ch%0d control before resync", l), 1, 0);
          end else if (lk[l][1:0] != ((l == 0) ? {SYNC_POL, SYNC_POL} : 2'b00)) begin
            report_mismatch($sformatf("ch%0d idle pair", l),
                            (l == 0) ? 32'({SYNC_POL, SYNC_POL}) : 0, 32'(lk[l][1:0]));
          end
        end
        return;
      end
    end
    active = (col < `H_ACTIVE) && (line < `V_ACTIVE);
    hs = ((col >= `H_ACTIVE + `H_FRONT) && (col < `H_ACTIVE + `H_FRONT + `H_SYNC)) ^ SYNC_POL;
    vs = ((line >= `V_ACTIVE + `V_FRONT) && (line < `V_ACTIVE + `V_FRONT + `V_SYNC)) ^ SYNC_POL;
    // data symbols as seen on the blue lane
    if (!lk[0][2]) begin
      data_in_line++;
    end
    if (active) begin
      for (int l = 0; l < 3; l++) begin
        exp_data = (l == 0) ? (col % `RAMP_MOD) : 0;
        if (lk[l][2]) begin
          report_mismatch($sformatf("ch%0d data enable", l), 1, 0);
        end else begin
          if (32'(decode_data(word[l])) != exp_data) begin
            report_mismatch($sformatf("ch%0d pixel", l), exp_data, 32'(decode_data(word[l])));
          end
          disp[l] = disp[l] + ones_minus_zeros(word[l]);
          if (disp[l] > 10 || disp[l] < -10) begin
            report_mismatch($sformatf("ch%0d running disparity", l), 10, disp[l]);
          end
        end
      end
    end else begin
      for (int l = 0; l < 3; l++) begin
        exp_pair = (l == 0) ? {vs, hs} : 2'b00;
        disp[l] = 0;
        if (!lk[l][2]) begin
          report_mismatch($sformatf("ch%0d control symbol", l), 1, 0);
        end else if (lk[l][1:0] != exp_pair) begin
          report_mismatch($sformatf("ch%0d control pair", l), 32'(exp_pair), 32'(lk[l][1:0]));
        end
      end
    end
    // advance model position
    if (col == H_TOTAL - 1) begin
      if (data_in_line != ((line < `V_ACTIVE) ? `H_ACTIVE : 0)) begin
        report_mismatch("data symbols per line", (line < `V_ACTIVE) ? `H_ACTIVE : 0,
                        data_in_line);
      end
      if (data_in_line > 0) begin
        active_lines++;
      end
      data_in_line = 0;
      col = 0;
      if (line == V_TOTAL - 1) begin
        if (active_lines != `V_ACTIVE) begin
          report_mismatch("active lines per frame", `V_ACTIVE, active_lines);
        end
        frames_done++;
        active_lines = 0;
        line = 0;
      end else begin
        line++;
      end
    end else begin
      col++;
    end
  endtask

  //////////////////////////////////////////////////
  // lane capture
  //////////////////////////////////////////////////

  always @(posedge clk50m_bufg) begin
    if (serdes_rst) begin
      aligned = 1'b0;
      synced = 1'b0;
      post_rst = 1'b1;
      prev3 = 1'b0;
      pos = 0;
    end else begin
      if (!aligned) begin
        if (!prev3 && tmds[3]) begin
          // word boundary found
          aligned = 1'b1;
          post_rst = 1'b0;
          pos = 0;
        end else if (post_rst && tmds != 4'b0000) begin
          report_mismatch("tmds before first load", 0, 32'(tmds));
        end
      end
      if (aligned) begin
        for (int l = 0; l < 4; l++) begin
          word[l][pos] = tmds[l];
        end
        pos++;
        if (pos == 10) begin
          check_word();
          pos = 0;
        end
      end
      prev3 = tmds[3];
    end
  end

endmodule

/* test/hdmi_tx_assertions.sv */
`timescale 1ns/100ps

module hdmi_tx_assertions (
  input logic       clk50m_bufg,
  input logic       serdes_rst,
  input logic       pixel_tick,
  input logic [3:0] tmds
);

  int fail_count = 0;

  //////////////////////////////////////////////////
  // pixel tick spacing
  //////////////////////////////////////////////////

  // tick is a single-cycle strobe
  tick_is_strobe: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
    pixel_tick |=> !pixel_tick)
  else begin
    $error("pixel_tick stayed high for more than one cycle");
    fail_count++;
  end

  // next tick exactly ten cycles later
  tick_every_ten: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
    pixel_tick |-> ##10 pixel_tick)
  else begin
    $error("pixel_tick did not recur after ten cycles");
    fail_count++;
  end

  //////////////////////////////////////////////////
  // clock lane and reset
  //////////////////////////////////////////////////

  // bit 0 of the clock word follows each load
  clock_lane_high: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
    pixel_tick |=> tmds[3])
  else begin
    $error("clock lane low right after a load");
    fail_count++;
  end

  // lane 3 only rises on a word boundary
  clock_lane_rise: assert property (@(posedge clk50m_bufg) disable iff (serdes_rst)
    $rose(tmds[3]) |-> $past(pixel_tick))
  else begin
    $error("clock lane rose away from a word boundary");
    fail_count++;
  end

  // output lanes idle while held in reset
  reset_quiet: assert property (@(posedge clk50m_bufg) serdes_rst |-> (tmds == 4'b0000))
  else begin
    $error("tmds lanes not zero during reset");
    fail_count++;
  end

endmodule

/* source/hdmi_tx_top.sv */
`timescale 1ns/100ps

module hdmi_tx_top (
  input  logic       clk50m_bufg,
  input  logic       serdes_rst,
  output logic [3:0] tmds
);

  import hdmi_pkg::*;

  logic        pixel_tick;
  raster_t     raster;
  pixel_t      pixel;
  video_ctrl_t ctrl;
  tmds_link_t  link;

  //////////////////////////////////////////////////
  // timing and pattern
  //////////////////////////////////////////////////

  video_timing video_timing_i (
    .clk50m_bufg (clk50m_bufg),
    .serdes_rst  (serdes_rst),
    .pixel_tick  (pixel_tick),
    .raster      (raster)
  );

  ramp_pattern ramp_pattern_i (
    .clk50m_bufg (clk50m_bufg),
    .serdes_rst  (serdes_rst),
    .pixel_tick  (pixel_tick),
    .raster      (raster),
    .pixel       (pixel),
    .ctrl        (ctrl)
  );

  //////////////////////////////////////////////////
  // encoders, sync rides on blue only
  //////////////////////////////////////////////////

  tmds_encoder tmds_encoder_ch0 (
    .clk50m_bufg (clk50m_bufg),
    .serdes_rst  (serdes_rst),
    .pixel_tick  (pixel_tick),
    .data        (pixel.blue),
    .ctl         ({ctrl.vsync, ctrl.hsync}),
    .de          (ctrl.de),
    .sym         (link.ch0)
  );

  tmds_encoder tmds_encoder_ch1 (
    .clk50m_bufg (clk50m_bufg),
    .serdes_rst  (serdes_rst),
    .pixel_tick  (pixel_tick),
    .data        (pixel.green),
    .ctl         (2'b00),
    .de          (ctrl.de),
    .sym         (link.ch1)
  );

  tmds_encoder tmds_encoder_ch2 (
    .clk50m_bufg (clk50m_bufg),
    .serdes_rst  (serdes_rst),
    .pixel_tick  (pixel_tick),
    .data        (pixel.red),
    .ctl         (2'b00),
    .de          (ctrl.de),
    .sym         (link.ch2)
  );

  // serializer also paces everything above
  tmds_serializer tmds_serializer_i (
    .clk50m_bufg (clk50m_bufg),
    .serdes_rst  (serdes_rst),
    .link        (link),
    .pixel_tick  (pixel_tick),
    .tmds        (tmds)
  );

endmodule

/* source/tmds_serializer.sv */
`timescale 1ns/100ps
`include "hdmi_cfg.svh"

module tmds_serializer (
  input  logic                 clk50m_bufg,
  input  logic                 serdes_rst,
  input  hdmi_pkg::tmds_link_t link,
  output logic                 pixel_tick,
  output logic [3:0]           tmds
);

  import hdmi_pkg::*;

  // clock lane, five ones then five zeros, lsb first
  localparam tmds_sym_t CLK_WORD = `SYM_W'(10'b0000011111);

  // last bit slot of a symbol
  localparam logic [3:0] BIT_LAST = 4'(`SYM_W - 1);

  logic [3:0]      bit_cnt;
  tmds_sym_t [3:0] shreg;

  //////////////////////////////////////////////////
  // bit counter and pixel tick
  //////////////////////////////////////////////////

  always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
    if (serdes_rst) begin
      bit_cnt <= '0;
    end else if (bit_cnt == BIT_LAST) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // one cycle in ten, while the last bit is on the wire
  assign pixel_tick = (bit_cnt == BIT_LAST);

  //////////////////////////////////////////////////
  // shift registers
  //////////////////////////////////////////////////

  // lane 3 is the clock, lanes 2..0 carry red, green, blue
  always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
    if (serdes_rst) begin
      shreg <= '0;
    end else if (pixel_tick) begin
      shreg[0] <= link.ch0;
      shreg[1] <= link.ch1;
      shreg[2] <= link.ch2;
      shreg[3] <= CLK_WORD;
    end else begin
      for (int i = 0; i < 4; i++) begin
        shreg[i] <= shreg[i] >> 1;
      end
    end
  end

  // wire bit is the lsb of each lane
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      tmds[i] = shreg[i][0];
    end
  end

endmodule

/* source/tmds_encoder.sv */
`timescale 1ns/100ps
`include "hdmi_cfg.svh"

module tmds_encoder (
  input  logic                clk50m_bufg,
  input  logic                serdes_rst,
  input  logic                pixel_tick,
  input  logic [7:0]          data,
  input  logic [1:0]          ctl,
  input  logic                de,
  output hdmi_pkg::tmds_sym_t sym
);

  import hdmi_pkg::*;

  // blanking symbols, one per control pair
  localparam tmds_sym_t CTL_00 = `SYM_W'(10'b1101010100);
  localparam tmds_sym_t CTL_01 = `SYM_W'(10'b0010101011);
  localparam tmds_sym_t CTL_10 = `SYM_W'(10'b0101010100);
  localparam tmds_sym_t CTL_11 = `SYM_W'(10'b1010101011);

  //////////////////////////////////////////////////
  // stage 1: transition minimizing
  //////////////////////////////////////////////////

  logic [3:0] n1_data;
  logic       use_xnor;
  logic [8:0] qm_d;
  logic [8:0] qm_q;
  logic       de_q;
  logic [1:0] ctl_q;

  assign n1_data = 4'($countones(data));

  // xnor chain when the byte is mostly ones, ties broken by bit 0
  assign use_xnor = (n1_data > 4'd4) || ((n1_data == 4'd4) && !data[0]);

  always_comb begin
    qm_d[0] = data[0];
    for (int i = 1; i < 8; i++) begin
      qm_d[i] = use_xnor ? ~(qm_d[i-1] ^ data[i]) : (qm_d[i-1] ^ data[i]);
    end
    // bit 8 set marks the xor form
    qm_d[8] = ~use_xnor;
  end

  always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
    if (serdes_rst) begin
      de_q  <= 1'b0;
      ctl_q <= 2'b00;
    end else if (pixel_tick) begin
      de_q  <= de;
      ctl_q <= ctl;
    end
  end

  always_ff @(posedge clk50m_bufg) begin
    if (pixel_tick) begin
      qm_q <= qm_d;
    end
  end

  //////////////////////////////////////////////////
  // stage 2: dc balance
  //////////////////////////////////////////////////

  logic [3:0]        n1_qm;
  logic [3:0]        n0_qm;
  logic signed [4:0] diff;
  logic signed [4:0] disp;
  logic signed [4:0] disp_d;
  logic              balanced;
  logic              invert;
  tmds_sym_t         sym_d;

  assign n1_qm = 4'($countones(qm_q[7:0]));
  assign n0_qm = 4'd8 - n1_qm;

  // ones minus zeros of the payload byte
  assign diff = $signed({1'b0, n1_qm}) - $signed({1'b0, n0_qm});

  // no bias either way, bit 8 alone picks inversion
  assign balanced = (disp == 5'sd0) || (diff == 5'sd0);

  // word leans the same way as the running disparity
  assign invert = ((disp > 5'sd0) && (diff > 5'sd0)) ||
                  ((disp < 5'sd0) && (diff < 5'sd0));

  always_comb begin
    if (!de_q) begin
      // blanking resets the balance
      disp_d = 5'sd0;
      case (ctl_q)
        2'b00:   sym_d = CTL_00;
        2'b01:   sym_d = CTL_01;
        2'b10:   sym_d = CTL_10;
        default: sym_d = CTL_11;
      endcase
    end else if (balanced) begin
      sym_d = {~qm_q[8], qm_q[8], qm_q[8] ? qm_q[7:0] : ~qm_q[7:0]};
      if (qm_q[8]) begin
        disp_d = disp + diff;
      end else begin
        disp_d = disp - diff;
      end
    end else if (invert) begin
      sym_d  = {1'b1, qm_q[8], ~qm_q[7:0]};
      disp_d = disp + (qm_q[8] ? 5'sd2 : 5'sd0) - diff;
    end else begin
      sym_d  = {1'b0, qm_q[8], qm_q[7:0]};
      disp_d = disp - (qm_q[8] ? 5'sd0 : 5'sd2) + diff;
    end
  end

  // reset value matches the idle control word
  always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
    if (serdes_rst) begin
      disp <= 5'sd0;
      sym  <= CTL_00;
    end else if (pixel_tick) begin
      disp <= disp_d;
      sym  <= sym_d;
    end
  end

endmodule

/* source/ramp_pattern.sv */
`timescale 1ns/100ps
`include "hdmi_cfg.svh"

module ramp_pattern (
  input  logic                  clk50m_bufg,
  input  logic                  serdes_rst,
  input  logic                  pixel_tick,
  input  hdmi_pkg::raster_t     raster,
  output hdmi_pkg::pixel_t      pixel,
  output hdmi_pkg::video_ctrl_t ctrl
);

  import hdmi_pkg::*;

  // sync polarity as a single bit
  localparam logic SYNC_POL = 1'(`SYNC_NEG);

  logic        active;
  logic [23:0] ramp_val;
  pixel_t      pixel_d;
  video_ctrl_t ctrl_d;

  assign active = !raster.hblnk && !raster.vblnk;

  // column ramp, lands in blue only
  assign ramp_val = 24'(raster.hcount % `CNT_W'(`RAMP_MOD));

  // black outside the active area
  assign pixel_d = active ? pixel_t'(ramp_val) : '0;

  assign ctrl_d.hsync = raster.hsync ^ SYNC_POL;
  assign ctrl_d.vsync = raster.vsync ^ SYNC_POL;
  assign ctrl_d.de    = active;

  // control resets to idle sync, de low
  always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
    if (serdes_rst) begin
      ctrl <= '{hsync: SYNC_POL, vsync: SYNC_POL, de: 1'b0};
    end else if (pixel_tick) begin
      ctrl <= ctrl_d;
    end
  end

  // pixel payload
  always_ff @(posedge clk50m_bufg) begin
    if (pixel_tick) begin
      pixel <= pixel_d;
    end
  end

endmodule

/* source/video_timing.sv */
`timescale 1ns/100ps
`include "hdmi_cfg.svh"

module video_timing (
  input  logic              clk50m_bufg,
  input  logic              serdes_rst,
  input  logic              pixel_tick,
  output hdmi_pkg::raster_t raster
);

  //////////////////////////////////////////////////
  // timing end points
  //////////////////////////////////////////////////

  // last active column, then sync start/end, then last column of the line
  localparam logic [`CNT_W-1:0] TC_HSBLNK = `CNT_W'(`H_ACTIVE - 1);
  localparam logic [`CNT_W-1:0] TC_HSSYNC = `CNT_W'(`H_ACTIVE - 1 + `H_FRONT);
  localparam logic [`CNT_W-1:0] TC_HESYNC =
    `CNT_W'(`H_ACTIVE - 1 + `H_FRONT + `H_SYNC);
  localparam logic [`CNT_W-1:0] TC_HEBLNK =
    `CNT_W'(`H_ACTIVE - 1 + `H_FRONT + `H_SYNC + `H_BACK);

  // same end points for lines
  localparam logic [`CNT_W-1:0] TC_VSBLNK = `CNT_W'(`V_ACTIVE - 1);
  localparam logic [`CNT_W-1:0] TC_VSSYNC = `CNT_W'(`V_ACTIVE - 1 + `V_FRONT);
  localparam logic [`CNT_W-1:0] TC_VESYNC =
    `CNT_W'(`V_ACTIVE - 1 + `V_FRONT + `V_SYNC);
  localparam logic [`CNT_W-1:0] TC_VEBLNK =
    `CNT_W'(`V_ACTIVE - 1 + `V_FRONT + `V_SYNC + `V_BACK);

  logic [`CNT_W-1:0] hcount;
  logic [`CNT_W-1:0] vcount;
  logic              line_end;
  logic              frame_end;

  assign line_end  = (hcount == TC_HEBLNK);
  assign frame_end = (vcount == TC_VEBLNK);

  //////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////

  // column advances once per pixel tick
  always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
    if (serdes_rst) begin
      hcount <= '0;
    end else if (pixel_tick) begin
      if (line_end) begin
        hcount <= '0;
      end else begin
        hcount <= hcount + 1'b1;
      end
    end
  end

  // line steps on the last column of each line
  always_ff @(posedge clk50m_bufg or posedge serdes_rst) begin
    if (serdes_rst) begin
      vcount <= '0;
    end else if (pixel_tick && line_end) begin
      if (frame_end) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  assign raster.hcount = hcount;
  assign raster.vcount = vcount;

  // blank once past the last active column or line
  assign raster.hblnk = (hcount > TC_HSBLNK);
  assign raster.vblnk = (vcount > TC_VSBLNK);

  // sync window runs from just after the sync start point up to its end
  // point, so hsync covers columns 18..21 and vsync lines 5..6
  assign raster.hsync = (hcount > TC_HSSYNC) && (hcount <= TC_HESYNC);
  assign raster.vsync = (vcount > TC_VSSYNC) && (vcount <= TC_VESYNC);

endmodule

/* source/hdmi_pkg.sv */
`include "hdmi_cfg.svh"

package hdmi_pkg;

  //////////////////////////////////////////////////
  // raster timing
  //////////////////////////////////////////////////

  // raw counter state and decoded blank/sync
  typedef struct packed {
    logic [`CNT_W-1:0] hcount;
    logic [`CNT_W-1:0] vcount;
    logic              hblnk;
    logic              vblnk;
    logic              hsync;
    logic              vsync;
  } raster_t;

  // sync after polarity, plus data enable
  typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;
  } video_ctrl_t;

  //////////////////////////////////////////////////
  // pixel and link payloads
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } pixel_t;

  typedef logic [`SYM_W-1:0] tmds_sym_t;

  // ch0 blue, ch1 green, ch2 red
  typedef struct packed {
    tmds_sym_t ch2;
    tmds_sym_t ch1;
    tmds_sym_t ch0;
  } tmds_link_t;

endpackage

/* source/hdmi_cfg.svh */
`ifndef HDMI_CFG_SVH
`define HDMI_CFG_SVH

// horizontal geometry in pixels, 25 per line
`define H_ACTIVE 16
`define H_FRONT 2
`define H_SYNC 4
`define H_BACK 3

// vertical geometry in lines, 8 per frame
`define V_ACTIVE 4
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 1

// width of both raster counters
`define CNT_W 11

// 1 gives active-low hsync and vsync
`define SYNC_NEG 0

// column ramp wraps at this value
`define RAMP_MOD 255

// bits per tmds symbol
`define SYM_W 10

`endif
